/* Makefile */
# Verilator flow for the cpu_core testbench

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_cpu_core
RTL_TOP    ?= cpu_core
OBJ_DIR    ?= obj_dir
SIM_BIN    ?= V$(TB_TOP)
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

RTL_FILES := $(filter design/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(SIM_BIN)
	$(OBJ_DIR)/$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL: run did not finish, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/core_pkg.sv */
package core_pkg;

    // datapath and instruction word width
    localparam int WORD_SIZE = 16;

    // general register file, r0 to r7
    localparam int NUM_REGS = 8;
    localparam int REG_BITS = $clog2(NUM_REGS);

    localparam int IMM_BITS = 9;    // immediate field of the instruction word

    // flag register, NZCV from msb down
    localparam int FLAG_BITS = 4;

    // first fetch address after reset
    localparam logic [WORD_SIZE-1:0] PC_RESET = '0;

endpackage

/* design/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core (
    input  logic                            Clock,
    input  logic                            Reset,
    output logic [core_pkg::WORD_SIZE-1:0]  instr_addr,
    input  logic [core_pkg::WORD_SIZE-1:0]  instr_word,
    input  logic                            instr_valid,
    output logic                            retire_valid,
    output logic                            retire_write,
    output logic [core_pkg::REG_BITS-1:0]   retire_reg,
    output logic [core_pkg::WORD_SIZE-1:0]  retire_data,
    output logic [core_pkg::FLAG_BITS-1:0]  retire_flags
);

    logic                           redirect_valid;   // taken branch in execute
    logic [core_pkg::WORD_SIZE-1:0] redirect_pc;

    decode_if  dec_if ();
    regfile_if rf_if ();

    // fetch and decode stages
    instr_decoder decoder_i (
        .Clock          (Clock),
        .Reset          (Reset),
        .instr_word     (instr_word),
        .instr_valid    (instr_valid),
        .instr_addr     (instr_addr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .dec            (dec_if.decoder)
    );

    register_file regfile_i (
        .Clock (Clock),
        .Reset (Reset),
        .rf    (rf_if.owner)
    );

    // execute and writeback
    execute_unit execute_i (
        .Clock          (Clock),
        .Reset          (Reset),
        .dec            (dec_if.execute),
        .rf             (rf_if.user),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .retire_valid   (retire_valid),
        .retire_write   (retire_write),
        .retire_reg     (retire_reg),
        .retire_data    (retire_data),
        .retire_flags   (retire_flags)
    );

endmodule

/* design/decode_if.sv */
`timescale 1ns/1ns

// decoded entry handed from the decode register to execute, one per cycle
interface decode_if;
    import core_pkg::*;
    import isa_pkg::*;

    logic                   valid;       // empty entry when low
    logic [ALU_BITS-1:0]    alu_op;
    logic [COND_BITS-1:0]   cond;
    logic                   is_branch;
    logic                   sets_flags;  // cmp only
    logic                   writes_reg;
    logic [REG_BITS-1:0]    rx;
    logic [REG_BITS-1:0]    ry;
    logic                   use_imm;     // operand y from imm_value instead of ry
    logic [WORD_SIZE-1:0]   imm_value;   // already extended, or shifted for mvt
    logic [WORD_SIZE-1:0]   next_pc;     // address of the instruction + 1

    modport decoder (output valid, alu_op, cond, is_branch, sets_flags, writes_reg,
                     rx, ry, use_imm, imm_value, next_pc);

    modport execute (input valid, alu_op, cond, is_branch, sets_flags, writes_reg,
                     rx, ry, use_imm, imm_value, next_pc);

endinterface

/* design/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit (
    input  logic                            Clock,
    input  logic                            Reset,
    decode_if.execute                       dec,
    regfile_if.user                         rf,
    output logic                            redirect_valid,
    output logic [core_pkg::WORD_SIZE-1:0]  redirect_pc,
    output logic                            retire_valid,
    output logic                            retire_write,
    output logic [core_pkg::REG_BITS-1:0]   retire_reg,
    output logic [core_pkg::WORD_SIZE-1:0]  retire_data,
    output logic [core_pkg::FLAG_BITS-1:0]  retire_flags
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [FLAG_BITS-1:0]   flags;        // n z c v
    logic [FLAG_BITS-1:0]   flags_next;
    logic [WORD_SIZE-1:0]   op_x;
    logic [WORD_SIZE-1:0]   op_y;
    logic [WORD_SIZE:0]     alu_full;     // msb is carry out, borrow for sub
    logic [WORD_SIZE-1:0]   result;
    logic [WORD_SIZE-1:0]   branch_target;
    logic                   cond_met;

    // operands come straight from the register file
    assign rf.rd_x_addr = dec.rx;
    assign rf.rd_y_addr = dec.ry;
    assign op_x = rf.rd_x_data;
    assign op_y = dec.use_imm ? dec.imm_value : rf.rd_y_data;

    always_comb begin
        case (dec.alu_op)
            ALU_MOV: alu_full = {1'b0, op_y};
            ALU_ADD: alu_full = {1'b0, op_x} + {1'b0, op_y};
            ALU_SUB: alu_full = {1'b0, op_x} - {1'b0, op_y};
            default: alu_full = '0;   // branch or nothing
        endcase
    end
    assign result = alu_full[WORD_SIZE-1:0];

    // nzcv of a cmp
    assign flags_next[3] = result[WORD_SIZE-1];
    assign flags_next[2] = (result == '0);
    assign flags_next[1] = alu_full[WORD_SIZE];
    assign flags_next[0] = (op_x[WORD_SIZE-1] != op_y[WORD_SIZE-1]) &&
                           (result[WORD_SIZE-1] != op_x[WORD_SIZE-1]);

    // condition is checked against the committed flags
    always_comb begin
        case (dec.cond)
            COND_NONE: cond_met = 1'b1;
            COND_EQ:   cond_met = flags[2];
            COND_NE:   cond_met = !flags[2];
            COND_CC:   cond_met = !flags[1];
            COND_CS:   cond_met = flags[1];
            COND_PL:   cond_met = !flags[2] && !flags[3];
            COND_MI:   cond_met = !flags[2] && flags[3];
            default:   cond_met = 1'b0;
        endcase
    end

    assign branch_target  = dec.next_pc + dec.imm_value;
    assign redirect_valid = dec.valid && dec.is_branch && cond_met;
    assign redirect_pc    = branch_target;

    // write lands at the end of this stage, next instruction reads it
    assign rf.wr_en   = dec.valid && dec.writes_reg;
    assign rf.wr_addr = dec.rx;
    assign rf.wr_data = result;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            retire_valid <= 1'b0;
            flags        <= '0;
        end else begin
            retire_valid <= dec.valid;
            if (dec.valid && dec.sets_flags)
                flags <= flags_next;
        end
    end

    // trace record, only refreshed when something executes
    always_ff @(posedge Clock) begin
        if (dec.valid) begin
            retire_write <= dec.writes_reg;
            retire_reg   <= dec.is_branch ? '0 : dec.rx;   // rx holds the condition there
            if (dec.is_branch)
                retire_data <= cond_met ? branch_target : dec.next_pc;
            else
                retire_data <= result;   // cmp reports its difference
        end
    end

    assign retire_flags = flags;   // moves only on a cmp retire

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  logic                            Clock,
    input  logic                            Reset,
    input  logic [core_pkg::WORD_SIZE-1:0]  instr_word,
    input  logic                            instr_valid,
    output logic [core_pkg::WORD_SIZE-1:0]  instr_addr,
    input  logic                            redirect_valid,
    input  logic [core_pkg::WORD_SIZE-1:0]  redirect_pc,
    decode_if.decoder                       dec
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [WORD_SIZE-1:0]   pc;
    logic                   fetch_valid;
    instr_word_u            fetch_word;
    logic [WORD_SIZE-1:0]   fetch_next_pc;   // pc + 1 at the time of the fetch

    // combinational decode of the fetch register
    logic                   d_ok;
    logic [ALU_BITS-1:0]    d_alu;
    logic [COND_BITS-1:0]   d_cond;
    logic                   d_branch;
    logic                   d_flags;
    logic                   d_write;
    logic                   d_use_imm;
    logic [WORD_SIZE-1:0]   d_value;
    logic [WORD_SIZE-1:0]   imm_sext;

    assign instr_addr = pc;   // memory answers in the same cycle

    assign imm_sext = {{(WORD_SIZE-IMM_BITS){fetch_word.imm_form.imm[IMM_BITS-1]}},
                       fetch_word.imm_form.imm};

    always_comb begin
        d_ok      = fetch_valid && (fetch_word != '0);   // all-zero word is a nop
        d_alu     = ALU_NONE;
        d_cond    = COND_NONE;
        d_branch  = 1'b0;
        d_flags   = 1'b0;
        d_write   = 1'b0;
        d_use_imm = fetch_word.imm_form.imm_flag;
        d_value   = imm_sext;
        case (fetch_word.reg_form.opcode)
            OPC_MV: begin
                d_alu   = ALU_MOV;
                d_write = 1'b1;
            end
            OPC_MVT_B: begin
                if (fetch_word.imm_form.imm_flag) begin
                    d_alu   = ALU_MOV;          // mvt, low byte cleared
                    d_write = 1'b1;
                    d_value = {fetch_word.imm_form.imm[7:0], 8'h00};
                end else begin
                    d_branch  = 1'b1;
                    d_cond    = fetch_word.imm_form.rx;
                    d_use_imm = 1'b1;          // offset always from the word
                    if (fetch_word.imm_form.rx > COND_MI)
                        d_ok = 1'b0;           // reserved condition
                end
            end
            OPC_ADD: begin
                d_alu   = ALU_ADD;
                d_write = 1'b1;
            end
            OPC_SUB: begin
                d_alu   = ALU_SUB;
                d_write = 1'b1;
            end
            OPC_OTHER: begin
                // cmp is either form as long as the reg form pad is clear
                if (fetch_word.imm_form.imm_flag || fetch_word.reg_form.zero == '0) begin
                    d_alu   = ALU_SUB;
                    d_flags = 1'b1;
                end else begin
                    d_ok = 1'b0;
                end
            end
            OPC_LD, OPC_ST, OPC_AND: d_ok = 1'b0;   // no data port in this core
        endcase
    end

    // pc and stage valids, a redirect wins over everything
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc          <= PC_RESET;
            fetch_valid <= 1'b0;
            dec.valid   <= 1'b0;
        end else if (redirect_valid) begin
            pc          <= redirect_pc;
            fetch_valid <= 1'b0;   // drop the wrong-path word
            dec.valid   <= 1'b0;   // and the entry behind the branch
        end else begin
            if (instr_valid)
                pc <= pc + 1'b1;
            fetch_valid <= instr_valid;   // bubble when memory has nothing
            dec.valid   <= d_ok;
        end
    end

    // payload of the fetch and decode registers
    always_ff @(posedge Clock) begin
        fetch_word     <= instr_word;
        fetch_next_pc  <= pc + 1'b1;
        dec.alu_op     <= d_alu;
        dec.cond       <= d_cond;
        dec.is_branch  <= d_branch;
        dec.sets_flags <= d_flags;
        dec.writes_reg <= d_write;
        dec.rx         <= fetch_word.reg_form.rx;
        dec.ry         <= fetch_word.reg_form.ry;
        dec.use_imm    <= d_use_imm;
        dec.imm_value  <= d_value;
        dec.next_pc    <= fetch_next_pc;
    end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    localparam int OPC_BITS = 3;
    localparam int ALU_BITS = 2;
    localparam int COND_BITS = 3;
    localparam int ZERO_BITS = core_pkg::IMM_BITS - core_pkg::REG_BITS;   // pad in reg form

    // major opcodes, top three bits of the word
    localparam logic [OPC_BITS-1:0] OPC_MV    = 3'd0;
    localparam logic [OPC_BITS-1:0] OPC_MVT_B = 3'd1;  // mvt when imm flag set, branch otherwise
    localparam logic [OPC_BITS-1:0] OPC_ADD   = 3'd2;
    localparam logic [OPC_BITS-1:0] OPC_SUB   = 3'd3;
    localparam logic [OPC_BITS-1:0] OPC_LD    = 3'd4;
    localparam logic [OPC_BITS-1:0] OPC_ST    = 3'd5;
    localparam logic [OPC_BITS-1:0] OPC_AND   = 3'd6;
    localparam logic [OPC_BITS-1:0] OPC_OTHER = 3'd7;  // cmp lives here

    // alu operations carried down the pipe
    localparam logic [ALU_BITS-1:0] ALU_NONE = 2'd0;
    localparam logic [ALU_BITS-1:0] ALU_MOV  = 2'd1;
    localparam logic [ALU_BITS-1:0] ALU_ADD  = 2'd2;
    localparam logic [ALU_BITS-1:0] ALU_SUB  = 2'd3;

    // branch conditions, taken straight from the rx field, code 7 is reserved
    localparam logic [COND_BITS-1:0] COND_NONE = 3'd0;
    localparam logic [COND_BITS-1:0] COND_EQ   = 3'd1;
    localparam logic [COND_BITS-1:0] COND_NE   = 3'd2;
    localparam logic [COND_BITS-1:0] COND_CC   = 3'd3;
    localparam logic [COND_BITS-1:0] COND_CS   = 3'd4;
    localparam logic [COND_BITS-1:0] COND_PL   = 3'd5;
    localparam logic [COND_BITS-1:0] COND_MI   = 3'd6;

    // one instruction word, read as either operand form
    typedef union packed {
        struct packed {
            logic [OPC_BITS-1:0]            opcode;
            logic                           imm_flag;
            logic [core_pkg::REG_BITS-1:0]  rx;
            logic [ZERO_BITS-1:0]           zero;     // must be zero for a reg form cmp
            logic [core_pkg::REG_BITS-1:0]  ry;
        } reg_form;
        struct packed {
            logic [OPC_BITS-1:0]            opcode;
            logic                           imm_flag;
            logic [core_pkg::REG_BITS-1:0]  rx;       // condition code for a branch
            logic [core_pkg::IMM_BITS-1:0]  imm;      // signed offset or constant
        } imm_form;
    } instr_word_u;

endpackage

/* design/regfile_if.sv */
`timescale 1ns/1ns

// two async read ports and one clocked write port
interface regfile_if;
    import core_pkg::*;

    logic [REG_BITS-1:0]    rd_x_addr;
    logic [WORD_SIZE-1:0]   rd_x_data;
    logic [REG_BITS-1:0]    rd_y_addr;
    logic [WORD_SIZE-1:0]   rd_y_data;

    logic                   wr_en;      // write lands on the next rising clock
    logic [REG_BITS-1:0]    wr_addr;
    logic [WORD_SIZE-1:0]   wr_data;

    // register file side
    modport owner (input rd_x_addr, rd_y_addr, wr_en, wr_addr, wr_data,
                   output rd_x_data, rd_y_data);

    // execute side
    modport user (output rd_x_addr, rd_y_addr, wr_en, wr_addr, wr_data,
                  input rd_x_data, rd_y_data);

endinterface

/* design/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic    Clock,
    input  logic    Reset,
    regfile_if.owner rf
);
    import core_pkg::*;

    logic [WORD_SIZE-1:0] regs [NUM_REGS];   // r0 to r7, pc lives in the decoder

    // single write port, result of the execute stage
    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (rf.wr_en) begin
            regs[rf.wr_addr] <= rf.wr_data;
        end
    end

    // reads are combinational, execute samples them in its own cycle
    assign rf.rd_x_data = regs[rf.rd_x_addr];
    assign rf.rd_y_data = regs[rf.rd_y_addr];

endmodule

/* dv/cpu_core_assert.sv */
`timescale 1ns/1ns

module cpu_core_assert (
    input logic                            Clock,
    input logic                            Reset,
    input logic                            instr_valid,
    input logic [core_pkg::WORD_SIZE-1:0]  instr_addr,
    input logic                            redirect_valid,
    input logic                            retire_valid,
    input logic                            retire_write,
    input logic [core_pkg::FLAG_BITS-1:0]  retire_flags
);

    // nothing retires while the core is held in reset
    retire_quiet_in_reset: assert property (@(posedge Clock) Reset |-> !retire_valid)
        else $error("retire_valid high while Reset is asserted");

    // no word taken and no branch redirect, so the fetch address must not move
    pc_holds_without_fetch: assert property (@(posedge Clock) disable iff (Reset)
        (!instr_valid && !redirect_valid) |=> $stable(instr_addr))
        else $error("instr_addr moved without instr_valid or a redirect");

    // new flags show up together with a retire record that wrote no register
    flags_move_on_cmp_only: assert property (@(posedge Clock) disable iff (Reset)
        $changed(retire_flags) |-> (retire_valid && !retire_write))
        else $error("retire_flags changed without a cmp retiring");

endmodule

bind cpu_core cpu_core_assert assert_i (
    .Clock          (Clock),
    .Reset          (Reset),
    .instr_valid    (instr_valid),
    .instr_addr     (instr_addr),
    .redirect_valid (redirect_valid),
    .retire_valid   (retire_valid),
    .retire_write   (retire_write),
    .retire_flags   (retire_flags)
);

/* dv/tb_cpu_core.sv */
`timescale 1ns/1ns

module tb_cpu_core;
    import core_pkg::*;
    import isa_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int DRAIN_CYCLES = 8;    // well past the three stage pipe

    // one expected trace entry
    typedef struct packed {
        logic                   write;
        logic [REG_BITS-1:0]    rreg;
        logic [WORD_SIZE-1:0]   data;
        logic [FLAG_BITS-1:0]   flags;
    } retire_rec_t;

    logic                   Clock;
    logic                   Reset;
    logic [WORD_SIZE-1:0]   instr_addr;
    logic [WORD_SIZE-1:0]   instr_word;
    logic                   instr_valid;
    logic                   retire_valid;
    logic                   retire_write;
    logic [REG_BITS-1:0]    retire_reg;
    logic [WORD_SIZE-1:0]   retire_data;
    logic [FLAG_BITS-1:0]   retire_flags;

    logic [WORD_SIZE-1:0]   imem [MEM_WORDS];   // instruction memory model
    int                     prog_len;
    retire_rec_t            exp_q [$];
    string                  test_name;
    int                     test_errors;
    int                     total_errors = 0;
    int                     tests_run = 0;
    int                     retired;
    int                     cycles = 0;
    int                     cycle_limit = 100;  // grows by ten per program word run

    cpu_core dut_i (
        .Clock        (Clock),
        .Reset        (Reset),
        .instr_addr   (instr_addr),
        .instr_word   (instr_word),
        .instr_valid  (instr_valid),
        .retire_valid (retire_valid),
        .retire_write (retire_write),
        .retire_reg   (retire_reg),
        .retire_data  (retire_data),
        .retire_flags (retire_flags)
    );

    // memory answers in the same cycle, zero past the end of the program
    assign instr_word = (instr_addr < 16'(prog_len)) ? imem[instr_addr[7:0]] : '0;

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    function automatic logic [WORD_SIZE-1:0] encode_word(input logic [2:0] opc,
            input logic immf, input logic [2:0] rx, input logic [8:0] low);
        return {opc, immf, rx, low};
    endfunction

    task automatic new_program();
        prog_len = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = '0;
    endtask

    task automatic put_word(input logic [WORD_SIZE-1:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    function automatic logic [WORD_SIZE-1:0] random_alu_word();
        logic [2:0] rx;
        logic [8:0] low;
        int         kind;
        rx   = 3'($urandom_range(0, 7));
        low  = 9'($urandom);
        kind = $urandom_range(0, 6);
        case (kind)
            0: return encode_word(OPC_MV, 1'b1, rx, low);
            1: return encode_word(OPC_MV, 1'b0, rx, {6'b0, low[2:0]});
            2: return encode_word(OPC_MVT_B, 1'b1, rx, low);   // mvt
            3: return encode_word(OPC_ADD, 1'b1, rx, low);
            4: return encode_word(OPC_ADD, 1'b0, rx, {6'b0, low[2:0]});
            5: return encode_word(OPC_SUB, 1'b1, rx, low);
            default: return encode_word(OPC_SUB, 1'b0, rx, {6'b0, low[2:0]});
        endcase
    endfunction

    // groups of load, cmp, branch on one condition, then the words it may skip
    task automatic make_branch_program();
        logic [8:0] a;
        logic [8:0] b;
        int         skip;
        new_program();
        for (int rep = 0; rep < 3; rep++) begin
            for (int c = 0; c < 7; c++) begin
                a = 9'($urandom);
                case ($urandom_range(0, 3))
                    0: b = a;
                    1: b = a + 9'd1;
                    2: b = a - 9'd1;
                    default: b = 9'($urandom);
                endcase
                skip = $urandom_range(0, 3);
                if ($urandom_range(0, 3) == 0)
                    put_word(encode_word(OPC_MVT_B, 1'b1, 3'd1, a));   // big values for v
                else
                    put_word(encode_word(OPC_MV, 1'b1, 3'd1, a));
                if ($urandom_range(0, 1) == 0) begin
                    put_word(encode_word(OPC_MV, 1'b1, 3'd2, b));
                    put_word(encode_word(OPC_OTHER, 1'b0, 3'd1, 9'd2));   // cmp r1, r2
                end else begin
                    put_word(encode_word(OPC_OTHER, 1'b1, 3'd1, b));      // cmp r1, #b
                end
                put_word(encode_word(OPC_MVT_B, 1'b0, 3'(c), 9'(skip)));
                for (int k = 0; k < skip; k++)
                    put_word(random_alu_word());
            end
        end
    endtask

    task automatic make_illegal_program();
        new_program();
        for (int i = 0; i < 48; i++) begin
            case ($urandom_range(0, 9))
                0: put_word(encode_word(OPC_LD, 1'($urandom), 3'($urandom), 9'($urandom)));
                1: put_word(encode_word(OPC_ST, 1'($urandom), 3'($urandom), 9'($urandom)));
                2: put_word(encode_word(OPC_AND, 1'($urandom), 3'($urandom), 9'($urandom)));
                3: put_word(encode_word(OPC_OTHER, 1'b0, 3'($urandom),
                                        {6'($urandom_range(1, 63)), 3'($urandom)}));
                4: put_word(encode_word(OPC_MVT_B, 1'b0, 3'd7, 9'($urandom)));   // cond 7
                5: put_word('0);
                6: put_word(encode_word(OPC_OTHER, 1'b1, 3'($urandom), 9'($urandom)));
                default: put_word(random_alu_word());
            endcase
        end
    endtask

    // architectural model, walks the program in order and lists every retire
    function automatic void build_expected();
        logic [WORD_SIZE-1:0] r [NUM_REGS];
        logic [WORD_SIZE-1:0] w;
        logic [WORD_SIZE-1:0] x;
        logic [WORD_SIZE-1:0] y;
        logic [WORD_SIZE-1:0] simm;
        logic [WORD_SIZE:0]   diff;
        logic [2:0]           opc;
        logic [2:0]           rx;
        logic                 immf;
        logic                 n, z, c, taken;
        logic [FLAG_BITS-1:0] nzcv;
        retire_rec_t          rec;
        int                   pc;
        exp_q.delete();
        for (int i = 0; i < NUM_REGS; i++)
            r[i] = '0;
        nzcv = '0;
        pc = 0;
        while (pc < prog_len) begin
            w    = imem[pc];
            opc  = w[15:13];
            immf = w[12];
            rx   = w[11:9];
            simm = {{7{w[8]}}, w[8:0]};
            x    = r[rx];
            y    = immf ? simm : r[w[2:0]];
            rec.write = 1'b1;
            rec.rreg  = rx;
            rec.data  = '0;
            rec.flags = nzcv;
            pc++;                                   // pc now holds address + 1
            if (w == '0)
                continue;
            case (opc)
                OPC_MV: rec.data = y;
                OPC_ADD: rec.data = x + y;
                OPC_SUB: rec.data = x - y;
                OPC_MVT_B: begin
                    if (immf) begin
                        rec.data = {w[7:0], 8'h00};
                    end else begin
                        if (rx == 3'd7)
                            continue;               // reserved condition
                        {n, z, c} = nzcv[3:1];
                        case (rx)
                            COND_EQ: taken = z;
                            COND_NE: taken = !z;
                            COND_CC: taken = !c;
                            COND_CS: taken = c;
                            COND_PL: taken = !(z || n);
                            COND_MI: taken = n && !z;
                            default: taken = 1'b1;  // always
                        endcase
                        rec.write = 1'b0;
                        rec.rreg  = '0;
                        rec.data  = taken ? 16'(pc) + simm : 16'(pc);
                        if (taken)
                            pc = int'(rec.data);
                    end
                end
                OPC_OTHER: begin
                    if (!immf && w[8:3] != 6'd0)
                        continue;                   // not a cmp
                    diff = {1'b0, x} - {1'b0, y};
                    nzcv = {diff[15], diff[15:0] == 16'h0, diff[16],
                            (x[15] != y[15]) && (diff[15] != x[15])};
                    rec.write = 1'b0;
                    rec.data  = diff[15:0];
                    rec.flags = nzcv;
                end
                default: continue;                  // ld, st, and
            endcase
            if (rec.write)
                r[rx] = rec.data;
            exp_q.push_back(rec);
        end
    endfunction

    // compare every retire with the next expected record
    always @(posedge Clock) begin
        retire_rec_t rec;
        if (!Reset && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("test %s: a retire arrived with no record left to expect, data 0x%0h",
                         test_name, retire_data);
                test_errors++;
            end else begin
                rec = exp_q.pop_front();
                check_value("retire_write", 32'(rec.write), 32'(retire_write));
                check_value("retire_reg", 32'(rec.rreg), 32'(retire_reg));
                check_value("retire_data", 32'(rec.data), 32'(retire_data));
                check_value("retire_flags", 32'(rec.flags), 32'(retire_flags));
                retired++;
            end
        end
    end

    always @(posedge Clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("the run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic reset_core();
        @(posedge Clock);
        Reset       <= 1'b1;
        instr_valid <= 1'b0;
        repeat (2) @(posedge Clock);
        Reset <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        retired     = 0;
    endtask

    task automatic finish_test(input int expected);
        tests_run++;
        total_errors += test_errors;
        $display("test %s done: %0d of %0d retires seen, %0d errors",
                 test_name, retired, expected, test_errors);
    endtask

    task automatic run_program(input string name, input bit gaps);
        int expected;
        start_test(name);
        build_expected();
        expected = exp_q.size();
        cycle_limit = cycle_limit + 10 * prog_len;
        reset_core();
        while (exp_q.size() != 0) begin
            @(posedge Clock);
            instr_valid <= gaps ? ($urandom_range(0, 3) != 0) : 1'b1;
        end
        instr_valid <= 1'b1;
        while (instr_addr < 16'(prog_len))   // trailing words must not retire either
            @(posedge Clock);
        repeat (DRAIN_CYCLES) @(posedge Clock);   // catches anything retiring late
        instr_valid <= 1'b0;
        finish_test(expected);
    endtask

    initial begin
        void'($urandom(32'h8078));
        Reset       = 1'b0;
        instr_valid = 1'b0;
        new_program();

        start_test("reset");
        reset_core();
        repeat (2) begin
            @(posedge Clock);
            check_value("instr_addr", 32'(PC_RESET), 32'(instr_addr));
            check_value("retire_valid", 32'(0), 32'(retire_valid));
        end
        finish_test(0);

        new_program();
        for (int i = 0; i < 40; i++)
            put_word(random_alu_word());
        run_program("alu_random", 1'b0);

        make_branch_program();
        run_program("cmp_branch", 1'b0);
        run_program("cmp_branch_gaps", 1'b1);   // same words, fetch stalls

        make_illegal_program();
        run_program("illegal_words", 1'b0);

        $display("%0d tests run, %0d errors in total", tests_run, total_errors);
        if (total_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* files.f */
design/core_pkg.sv
design/isa_pkg.sv
design/decode_if.sv
design/regfile_if.sv
design/instr_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/cpu_core.sv
dv/cpu_core_assert.sv
dv/tb_cpu_core.sv
